// File: vmul_unit.f
+incdir+bench
src/vmul_pkg.sv
src/vmul_issue_if.sv
src/vmul_insn_queue.sv
src/simd_mul.sv
src/vmul_array.sv
src/vmul_result_queue.sv
src/vmul_unit.sv
bench/tb_vmul_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_vmul_unit \
  -f vmul_unit.f -o tb_vmul_unit || { echo "Build failed"; exit 1; }
out=$(./obj_dir/tb_vmul_unit)
echo "$out"
echo "$out" | grep -q "^TEST PASSED$" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: bench/tb_vmul_model.svh
// Reference model of the vector multiply unit
// Builds random instructions, their operand words and the result words
// that the register file must receive, in acceptance order
`ifndef TB_VMUL_MODEL_SVH
`define TB_VMUL_MODEL_SVH

vmul_insn_t   test_insn_q [$];
int           test_tag_q [$];
elen_t        vs1_q [$];
elen_t        vs2_q [$];
elen_t        vd_q [$];
vmul_result_t exp_q [$];
bit           exp_last_q [$];

function automatic int rand_below(int n);
  int r;
  r = $random(seed) & 32'h7fffffff;
  return r % n;
endfunction

function automatic elen_t rand_word();
  return {$random(seed), $random(seed)};
endfunction

function automatic logic [63:0] lane_mask(int w);
  return (w == 64) ? 64'hffff_ffff_ffff_ffff : ((64'd1 << w) - 64'd1);
endfunction

// Low element of the scalar copied into every lane
function automatic elen_t replicate(vew_e sew, elen_t s);
  int    w;
  elen_t res;
  w   = 8 << sew;
  res = '0;
  for (int l = 0; l < 64 / w; l++)
    res = res | ((s & lane_mask(w)) << (l * w));
  return res;
endfunction

// Per-lane arithmetic, each lane wraps at its own width
function automatic elen_t compute_word(mul_op_e op, vew_e sew, elen_t a, elen_t b, elen_t c);
  int          w;
  logic [63:0] la, lb, lc, r;
  elen_t       res;
  w   = 8 << sew;
  res = '0;
  for (int l = 0; l < 64 / w; l++) begin
    la = (a >> (l * w)) & lane_mask(w);
    lb = (b >> (l * w)) & lane_mask(w);
    lc = (c >> (l * w)) & lane_mask(w);
    case (op)
      VMACC:   r = lc + la * lb;
      VNMSAC:  r = lc - la * lb;
      default: r = la * lb;
    endcase
    res = res | ((r & lane_mask(w)) << (l * w));
  end
  return res;
endfunction

// Mode follows the test index: vv, scalar, accumulate, partial, stress
function automatic vmul_insn_t make_insn(int mode, int idx);
  vmul_insn_t insn;
  int         epw;
  insn.id         = vid_t'(idx % 8);
  insn.vsew       = vew_e'(rand_below(4));
  insn.op         = mul_op_e'(rand_below(3));
  insn.use_scalar = (rand_below(2) == 1);
  insn.vd         = vreg_t'(rand_below(32));
  insn.scalar     = rand_word();
  case (mode)
    0: begin
      insn.vsew       = vew_e'(idx % 4);
      insn.op         = VMUL;
      insn.use_scalar = 1'b0;
    end
    1: insn.use_scalar = 1'b1;
    2: insn.op = (idx % 2 == 0) ? VMACC : VNMSAC;
    default: ;
  endcase
  epw = 8 >> insn.vsew;
  if (mode >= 3) begin
    insn.vl = vlen_t'(1 + rand_below(40));
    if (mode == 3 && epw > 1 && insn.vl % epw == 0)
      insn.vl = insn.vl + 1'b1;
  end else begin
    insn.vl = vlen_t'(epw * (1 + rand_below(4)));
  end
  return insn;
endfunction

// Called when the DUT takes an instruction
task automatic accept_insn(vmul_insn_t insn);
  int           epw, nwords, elems, nbytes;
  elen_t        a, b, c;
  vmul_result_t r;
  epw    = 8 >> insn.vsew;
  nwords = (int'(insn.vl) + epw - 1) / epw;
  for (int k = 0; k < nwords; k++) begin
    a = rand_word();
    b = rand_word();
    c = rand_word();
    if (insn.use_scalar)
      a = replicate(insn.vsew, insn.scalar);
    else
      vs1_q.push_back(a);
    vs2_q.push_back(b);
    if (insn.op != VMUL)
      vd_q.push_back(c);
    elems   = (k == nwords - 1) ? int'(insn.vl) - k * epw : epw;
    nbytes  = elems << insn.vsew;
    r.id    = insn.id;
    r.addr  = ResAddrWidth'((int'(insn.vd) * WordsPerVReg + k) % 256);
    r.wdata = compute_word(insn.op, insn.vsew, a, b, c);
    r.be    = strb_t'((9'd1 << nbytes) - 9'd1);
    exp_q.push_back(r);
    exp_last_q.push_back(k == nwords - 1);
  end
endtask

`endif

// File: bench/tb_vmul_unit.sv
// Testbench of the vector integer multiply unit
// Random instructions with throttled operands and grants, every granted
// word compared with the reference model
`timescale 1ns/1ps
module tb_vmul_unit;
  import vmul_pkg::*;

  localparam int NumTests    = 5;
  localparam int HalfPeriod  = 10;
  localparam int ResetCycles = 16;
  localparam int InsnDepth   = 4;

  logic               clk_i;
  logic               rst_ni;
  logic               op_valid_i;
  logic               op_ready_o;
  vid_t               insn_id_i;
  mul_op_e            insn_op_i;
  vew_e               insn_vsew_i;
  vlen_t              insn_vl_i;
  vreg_t              insn_vd_i;
  logic               insn_use_scalar_i;
  elen_t              insn_scalar_i;
  elen_t [2:0]        operand_i;
  logic [2:0]         operand_valid_i;
  logic [2:0]         operand_ready_o;
  logic               result_req_o;
  vid_t               result_id_o;
  logic [7:0]         result_addr_o;
  elen_t              result_wdata_o;
  strb_t              result_be_o;
  logic               result_gnt_i;
  logic [NrVInsn-1:0] done_o;

  integer       seed;
  int           total_errors;
  int           total_words;
  int           test_errors;
  int           test_words;
  int           uncommitted;
  int           watchdog_cycles;
  bit           stimulus_ready;
  bit           held;
  vmul_result_t held_word;
  string        test_name [NumTests];
  int           insn_count [NumTests];
  int           grant_pct [NumTests];
  int           operand_pct [NumTests];

  `include "tb_vmul_model.svh"

  vmul_unit #(
    .InsnQueueDepth  (InsnDepth),
    .ResultQueueDepth(2),
    .VAddrWidth      (8)
  ) dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .op_valid_i       (op_valid_i),
    .op_ready_o       (op_ready_o),
    .insn_id_i        (insn_id_i),
    .insn_op_i        (insn_op_i),
    .insn_vsew_i      (insn_vsew_i),
    .insn_vl_i        (insn_vl_i),
    .insn_vd_i        (insn_vd_i),
    .insn_use_scalar_i(insn_use_scalar_i),
    .insn_scalar_i    (insn_scalar_i),
    .operand_i        (operand_i),
    .operand_valid_i  (operand_valid_i),
    .operand_ready_o  (operand_ready_o),
    .result_req_o     (result_req_o),
    .result_id_o      (result_id_o),
    .result_addr_o    (result_addr_o),
    .result_wdata_o   (result_wdata_o),
    .result_be_o      (result_be_o),
    .result_gnt_i     (result_gnt_i),
    .done_o           (done_o)
  );

  always #HalfPeriod clk_i = ~clk_i;

  task automatic check_value(string name, logic [63:0] got, logic [63:0] expected);
    assert (got === expected) else begin
      $display("Error: %s got %h expected %h", name, got, expected);
      test_errors++;
    end
  endtask

  task automatic idle_inputs();
    op_valid_i        = 1'b0;
    insn_id_i         = '0;
    insn_op_i         = VMUL;
    insn_vsew_i       = EW8;
    insn_vl_i         = '0;
    insn_vd_i         = '0;
    insn_use_scalar_i = 1'b0;
    insn_scalar_i     = '0;
    operand_i         = '0;
    operand_valid_i   = '0;
    result_gnt_i      = 1'b0;
  endtask

  // Falling edge drive, operand heads come from the model queues
  task automatic drive_inputs(int t);
    bit have_insn;
    have_insn  = (test_insn_q.size() != 0) && (test_tag_q[0] == t);
    op_valid_i = have_insn && (rand_below(100) < 70);
    if (have_insn) begin
      insn_id_i         = test_insn_q[0].id;
      insn_op_i         = test_insn_q[0].op;
      insn_vsew_i       = test_insn_q[0].vsew;
      insn_vl_i         = test_insn_q[0].vl;
      insn_vd_i         = test_insn_q[0].vd;
      insn_use_scalar_i = test_insn_q[0].use_scalar;
      insn_scalar_i     = test_insn_q[0].scalar;
    end
    operand_valid_i[0] = (vs1_q.size() != 0) && (rand_below(100) < operand_pct[t]);
    operand_valid_i[1] = (vs2_q.size() != 0) && (rand_below(100) < operand_pct[t]);
    operand_valid_i[2] = (vd_q.size() != 0) && (rand_below(100) < operand_pct[t]);
    operand_i[0] = (vs1_q.size() != 0) ? vs1_q[0] : '0;
    operand_i[1] = (vs2_q.size() != 0) ? vs2_q[0] : '0;
    operand_i[2] = (vd_q.size() != 0) ? vd_q[0] : '0;
    result_gnt_i = (rand_below(100) < grant_pct[t]);
  endtask

  // Runs shortly before the rising edge, when all handshakes are settled
  task automatic sample_outputs();
    logic [NrVInsn-1:0] exp_done;
    vmul_result_t       exp;
    bit                 last;
    check_value("op_ready_o", op_ready_o, uncommitted != InsnDepth);
    for (int ch = 0; ch < 3; ch++) begin
      assert (!(operand_ready_o[ch] && !operand_valid_i[ch])) else begin
        $display("Operand %0d was taken while it was not offered", ch);
        test_errors++;
      end
    end
    if (operand_valid_i[0] && operand_ready_o[0])
      void'(vs1_q.pop_front());
    if (operand_valid_i[1] && operand_ready_o[1])
      void'(vs2_q.pop_front());
    if (operand_valid_i[2] && operand_ready_o[2])
      void'(vd_q.pop_front());

    // A request that was not granted must not move
    if (held) begin
      check_value("result_req_o", result_req_o, 1'b1);
      check_value("result_id_o", result_id_o, held_word.id);
      check_value("result_addr_o", result_addr_o, held_word.addr);
      check_value("result_wdata_o", result_wdata_o, held_word.wdata);
      check_value("result_be_o", result_be_o, held_word.be);
    end

    exp_done = '0;
    if (result_req_o && result_gnt_i) begin
      assert (exp_q.size() != 0) else begin
        $display("A word was granted while no result was expected");
        test_errors++;
      end
      if (exp_q.size() != 0) begin
        exp  = exp_q.pop_front();
        last = exp_last_q.pop_front();
        check_value("result_id_o", result_id_o, exp.id);
        check_value("result_addr_o", result_addr_o, exp.addr);
        check_value("result_wdata_o", result_wdata_o, exp.wdata);
        check_value("result_be_o", result_be_o, exp.be);
        test_words++;
        if (last) begin
          exp_done[exp.id] = 1'b1;
          uncommitted--;
        end
      end
    end
    check_value("done_o", done_o, exp_done);

    held            = result_req_o && !result_gnt_i;
    held_word.id    = result_id_o;
    held_word.addr  = result_addr_o;
    held_word.wdata = result_wdata_o;
    held_word.be    = result_be_o;

    if (op_valid_i && op_ready_o) begin
      accept_insn(test_insn_q.pop_front());
      void'(test_tag_q.pop_front());
      uncommitted++;
    end
  endtask

  task automatic run_test(int t);
    test_errors = 0;
    test_words  = 0;
    while (((test_insn_q.size() != 0) && (test_tag_q[0] == t)) || (exp_q.size() != 0)) begin
      @(negedge clk_i);
      drive_inputs(t);
      #(HalfPeriod - 2);
      sample_outputs();
    end
    $display("Test %0d %s: %0d words checked, %0d errors",
             t, test_name[t], test_words, test_errors);
    total_errors += test_errors;
    total_words  += test_words;
  endtask

  initial begin
    vmul_insn_t insn;
    int         idx;
    int         total_elems;
    seed           = 32'h69acddd5;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    held           = 1'b0;
    uncommitted    = 0;
    total_errors   = 0;
    total_words    = 0;
    stimulus_ready = 1'b0;
    idle_inputs();

    test_name[0] = "vmul vector-vector";
    test_name[1] = "scalar operand";
    test_name[2] = "vmacc and vnmsac";
    test_name[3] = "partial last word";
    test_name[4] = "grant stalls";
    insn_count  = '{8, 8, 8, 12, 24};
    grant_pct   = '{90, 90, 80, 80, 30};
    operand_pct = '{80, 80, 70, 70, 50};

    idx         = 0;
    total_elems = 0;
    for (int t = 0; t < NumTests; t++) begin
      for (int i = 0; i < insn_count[t]; i++) begin
        insn = make_insn(t, idx);
        idx++;
        test_insn_q.push_back(insn);
        test_tag_q.push_back(t);
        total_elems += int'(insn.vl);
      end
    end
    watchdog_cycles = total_elems * 20 + 1000 + ResetCycles;
    stimulus_ready  = 1'b1;

    repeat (ResetCycles) @(negedge clk_i);
    test_errors = 0;
    check_value("op_ready_o", op_ready_o, 1'b1);
    check_value("operand_ready_o", operand_ready_o, 3'b000);
    check_value("result_req_o", result_req_o, 1'b0);
    check_value("done_o", done_o, '0);
    total_errors += test_errors;
    rst_ni = 1'b1;

    for (int t = 0; t < NumTests; t++)
      run_test(t);

    $display("Summary: %0d tests, %0d words checked, %0d errors",
             NumTests, total_words, total_errors);
    if (total_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Limit scales with the number of elements in all tests
  initial begin
    wait (stimulus_ready);
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the unit stopped making progress",
             watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: src/vmul_unit.sv
// Vector integer multiply unit of one lane
// Instruction queue, SIMD multiplier array and result queue
`timescale 1ns/1ps
module vmul_unit #(
  parameter int unsigned InsnQueueDepth   = 4,
  parameter int unsigned ResultQueueDepth = 2,
  parameter int unsigned VAddrWidth       = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Instruction input
  input  logic                         op_valid_i,
  output logic                         op_ready_o,
  input  vmul_pkg::vid_t               insn_id_i,
  input  vmul_pkg::mul_op_e            insn_op_i,
  input  vmul_pkg::vew_e               insn_vsew_i,
  input  vmul_pkg::vlen_t              insn_vl_i,
  input  vmul_pkg::vreg_t              insn_vd_i,
  input  logic                         insn_use_scalar_i,
  input  vmul_pkg::elen_t              insn_scalar_i,
  // Operands: vs1, vs2, vd
  input  vmul_pkg::elen_t [2:0]        operand_i,
  input  logic [2:0]                   operand_valid_i,
  output logic [2:0]                   operand_ready_o,
  // Register-file write request
  output logic                         result_req_o,
  output vmul_pkg::vid_t               result_id_o,
  output logic [VAddrWidth-1:0]        result_addr_o,
  output vmul_pkg::elen_t              result_wdata_o,
  output vmul_pkg::strb_t              result_be_o,
  input  logic                         result_gnt_i,
  output logic [vmul_pkg::NrVInsn-1:0] done_o
);
  import vmul_pkg::*;

  vmul_insn_t   insn;
  vew_e         out_vsew;
  logic         res_valid;
  logic         res_ready;
  elen_t        res_data;
  logic         push;
  vmul_result_t push_data;
  logic         rq_full;

  assign insn = '{
    id:         insn_id_i,
    op:         insn_op_i,
    vsew:       insn_vsew_i,
    vl:         insn_vl_i,
    vd:         insn_vd_i,
    use_scalar: insn_use_scalar_i,
    scalar:     insn_scalar_i
  };

  vmul_issue_if issue_if ();

  vmul_insn_queue #(
    .InsnQueueDepth(InsnQueueDepth),
    .VAddrWidth    (VAddrWidth)
  ) i_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .op_i           (insn),
    .op_valid_i     (op_valid_i),
    .op_ready_o     (op_ready_o),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .issue          (issue_if.issuer),
    .out_vsew_o     (out_vsew),
    .res_valid_i    (res_valid),
    .res_data_i     (res_data),
    .res_ready_o    (res_ready),
    .push_o         (push),
    .push_data_o    (push_data),
    .rq_full_i      (rq_full),
    .gnt_i          (result_gnt_i & result_req_o),
    .done_o         (done_o)
  );

  vmul_array i_array (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .issue      (issue_if.executor),
    .out_vsew_i (out_vsew),
    .res_valid_o(res_valid),
    .res_data_o (res_data),
    .res_ready_i(res_ready)
  );

  vmul_result_queue #(
    .ResultQueueDepth(ResultQueueDepth),
    .VAddrWidth      (VAddrWidth)
  ) i_result_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (push),
    .push_data_i(push_data),
    .full_o     (rq_full),
    .req_o      (result_req_o),
    .id_o       (result_id_o),
    .addr_o     (result_addr_o),
    .wdata_o    (result_wdata_o),
    .be_o       (result_be_o),
    .gnt_i      (result_gnt_i)
  );

endmodule

// File: src/vmul_result_queue.sv
// Result FIFO in front of the register-file write port
// The head entry is presented as a write request until granted
`timescale 1ns/1ps
module vmul_result_queue #(
  parameter int unsigned ResultQueueDepth = 2,
  parameter int unsigned VAddrWidth       = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  vmul_pkg::vmul_result_t push_data_i,
  output logic                   full_o,
  output logic                   req_o,
  output vmul_pkg::vid_t         id_o,
  output logic [VAddrWidth-1:0]  addr_o,
  output vmul_pkg::elen_t        wdata_o,
  output vmul_pkg::strb_t        be_o,
  input  logic                   gnt_i
);
  import vmul_pkg::*;

  localparam int unsigned PtrWidth = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [PtrWidth:0]   cnt_t;

  vmul_result_t mem_q [ResultQueueDepth];
  vmul_result_t head;
  ptr_t         wr_pnt_q;
  ptr_t         rd_pnt_q;
  cnt_t         cnt_q;
  logic         push;
  logic         pop;

  function automatic ptr_t next_pnt(ptr_t pnt);
    return (pnt == ptr_t'(ResultQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign full_o = (cnt_q == cnt_t'(ResultQueueDepth));
  assign req_o  = (cnt_q != '0);
  assign push   = push_i && !full_o;
  assign pop    = gnt_i && req_o;

  assign head    = mem_q[rd_pnt_q];
  assign id_o    = head.id;
  assign addr_o  = head.addr[VAddrWidth-1:0];
  assign wdata_o = head.wdata;
  assign be_o    = head.be;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push)
        wr_pnt_q <= next_pnt(wr_pnt_q);
      if (pop)
        rd_pnt_q <= next_pnt(rd_pnt_q);
      cnt_q <= cnt_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      mem_q[wr_pnt_q] <= push_data_i;
  end

endmodule

// File: src/vmul_array.sv
// Multiplier array with one SIMD multiplier per element width
// Replicates the scalar operand, steers issues by width and returns
// results from the multiplier of the instruction being processed
`timescale 1ns/1ps
module vmul_array (
  input  logic            clk_i,
  input  logic            rst_ni,
  vmul_issue_if.executor  issue,
  input  vmul_pkg::vew_e  out_vsew_i,
  output logic            res_valid_o,
  output vmul_pkg::elen_t res_data_o,
  input  logic            res_ready_i
);
  import vmul_pkg::*;

  elen_t       scalar_rep;
  elen_t       operand_a;
  elen_t [3:0] mul_result;
  logic  [3:0] in_valid;
  logic  [3:0] in_ready;
  logic  [3:0] out_valid;
  logic  [3:0] out_ready;

  // Low element of the scalar fills every lane
  always_comb begin
    unique case (issue.vsew)
      EW8:     scalar_rep = {8{issue.scalar[7:0]}};
      EW16:    scalar_rep = {4{issue.scalar[15:0]}};
      EW32:    scalar_rep = {2{issue.scalar[31:0]}};
      default: scalar_rep = issue.scalar;
    endcase
  end

  assign operand_a = issue.use_scalar ? scalar_rep : issue.operand_a;

  for (genvar w = 0; w < 4; w++) begin : gen_mul
    localparam vew_e Sew = vew_e'(w);
    localparam int unsigned Lat = (w == 0) ? LatMulEW8 :
                                  (w == 1) ? LatMulEW16 :
                                  (w == 2) ? LatMulEW32 : LatMulEW64;

    assign in_valid[w]  = issue.valid && (issue.vsew == Sew);
    assign out_ready[w] = res_ready_i && (out_vsew_i == Sew);

    simd_mul #(
      .ElementWidth(Sew),
      .NumPipeRegs (Lat)
    ) i_simd_mul (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .operand_a_i(operand_a),
      .operand_b_i(issue.operand_b),
      .operand_c_i(issue.operand_c),
      .op_i       (issue.op),
      .valid_i    (in_valid[w]),
      .ready_o    (in_ready[w]),
      .result_o   (mul_result[w]),
      .valid_o    (out_valid[w]),
      .ready_i    (out_ready[w])
    );
  end

  assign issue.ready = in_ready[issue.vsew];

  // Results drain in order from the processing instruction's width
  assign res_valid_o = out_valid[out_vsew_i];
  assign res_data_o  = mul_result[out_vsew_i];

endmodule

// File: src/simd_mul.sv
// SIMD integer multiply-accumulate for one element width
// Each lane wraps modulo 2^width, results pass a stallable pipeline
`timescale 1ns/1ps
module simd_mul #(
  parameter vmul_pkg::vew_e ElementWidth = vmul_pkg::EW64,
  parameter int unsigned    NumPipeRegs  = 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  vmul_pkg::elen_t   operand_a_i,
  input  vmul_pkg::elen_t   operand_b_i,
  input  vmul_pkg::elen_t   operand_c_i,
  input  vmul_pkg::mul_op_e op_i,
  input  logic              valid_i,
  output logic              ready_o,
  output vmul_pkg::elen_t   result_o,
  output logic              valid_o,
  input  logic              ready_i
);
  import vmul_pkg::*;

  localparam int unsigned LaneWidth = 8 << ElementWidth;
  localparam int unsigned NumLanes  = ElenWidth / LaneWidth;

  elen_t                   result_d;
  elen_t [NumPipeRegs-1:0] stage_q;
  logic  [NumPipeRegs-1:0] valid_q;

  for (genvar l = 0; l < NumLanes; l++) begin : gen_lane
    logic [LaneWidth-1:0] lane_a;
    logic [LaneWidth-1:0] lane_b;
    logic [LaneWidth-1:0] lane_c;
    logic [LaneWidth-1:0] prod;

    assign lane_a = operand_a_i[l*LaneWidth +: LaneWidth];
    assign lane_b = operand_b_i[l*LaneWidth +: LaneWidth];
    assign lane_c = operand_c_i[l*LaneWidth +: LaneWidth];
    // Low half of the product only
    assign prod   = lane_a * lane_b;

    assign result_d[l*LaneWidth +: LaneWidth] = (op_i == VMACC)  ? lane_c + prod :
                                                (op_i == VNMSAC) ? lane_c - prod : prod;
  end

  // The whole pipe moves only when the last stage can drain
  assign ready_o  = ready_i || !valid_q[NumPipeRegs-1];
  assign valid_o  = valid_q[NumPipeRegs-1];
  assign result_o = stage_q[NumPipeRegs-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (ready_o) begin
      valid_q[0] <= valid_i;
      for (int s = 1; s < NumPipeRegs; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      stage_q[0] <= result_d;
      for (int s = 1; s < NumPipeRegs; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

endmodule

// File: src/vmul_insn_queue.sv
// Vector instruction queue of the multiply unit
// Tracks instructions through issue, processing and commit, feeds the
// multiplier array and builds register-file write payloads
`timescale 1ns/1ps
module vmul_insn_queue #(
  parameter int unsigned InsnQueueDepth = 4,
  parameter int unsigned VAddrWidth     = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  vmul_pkg::vmul_insn_t         op_i,
  input  logic                         op_valid_i,
  output logic                         op_ready_o,
  input  vmul_pkg::elen_t [2:0]        operand_i,
  input  logic [2:0]                   operand_valid_i,
  output logic [2:0]                   operand_ready_o,
  vmul_issue_if.issuer                 issue,
  output vmul_pkg::vew_e               out_vsew_o,
  input  logic                         res_valid_i,
  input  vmul_pkg::elen_t              res_data_i,
  output logic                         res_ready_o,
  output logic                         push_o,
  output vmul_pkg::vmul_result_t       push_data_o,
  input  logic                         rq_full_i,
  input  logic                         gnt_i,
  output logic [vmul_pkg::NrVInsn-1:0] done_o
);
  import vmul_pkg::*;

  localparam int unsigned PtrWidth = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [PtrWidth:0]   cnt_t;

  vmul_insn_t insn_q [InsnQueueDepth];

  // One pointer per phase
  ptr_t accept_pnt_d, accept_pnt_q;
  ptr_t issue_pnt_d, issue_pnt_q;
  ptr_t proc_pnt_d, proc_pnt_q;
  ptr_t commit_pnt_d, commit_pnt_q;
  // Instructions still waiting in each phase
  cnt_t issue_cnt_d, issue_cnt_q;
  cnt_t proc_cnt_d, proc_cnt_q;
  cnt_t commit_cnt_d, commit_cnt_q;
  // Elements left of the head instruction of each phase
  vlen_t issue_rem_d, issue_rem_q;
  vlen_t proc_rem_d, proc_rem_q;
  vlen_t commit_rem_d, commit_rem_q;

  vmul_insn_t            issue_insn;
  vmul_insn_t            proc_insn;
  vmul_insn_t            commit_insn;
  logic                  operands_ok;
  vlen_t                 proc_elems;
  vlen_t                 word_idx;
  logic [3:0]            nbytes;
  logic [15:0]           be_mask;
  logic [VAddrWidth-1:0] proc_addr;

  function automatic ptr_t next_pnt(ptr_t pnt);
    return (pnt == ptr_t'(InsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Elements in one word, capped by what is left
  function automatic vlen_t word_elems(vew_e sew, vlen_t rem);
    vlen_t per_word;
    per_word = vlen_t'(8) >> sew;
    return (rem < per_word) ? rem : per_word;
  endfunction

  assign issue_insn  = insn_q[issue_pnt_q];
  assign proc_insn   = insn_q[proc_pnt_q];
  assign commit_insn = insn_q[commit_pnt_q];

  assign op_ready_o = (commit_cnt_q != cnt_t'(InsnQueueDepth));
  assign out_vsew_o = proc_insn.vsew;

  // vs1 is replaced by a scalar, vd only feeds the accumulating forms
  assign operands_ok = (operand_valid_i[0] || issue_insn.use_scalar) && operand_valid_i[1] &&
                       (operand_valid_i[2] || issue_insn.op == VMUL);

  assign issue.valid      = (issue_cnt_q != '0) && operands_ok;
  assign issue.op         = issue_insn.op;
  assign issue.vsew       = issue_insn.vsew;
  assign issue.use_scalar = issue_insn.use_scalar;
  assign issue.scalar     = issue_insn.scalar;
  assign issue.operand_a  = operand_i[0];
  assign issue.operand_b  = operand_i[1];
  assign issue.operand_c  = operand_i[2];

  // Payload of the word leaving the array
  assign proc_elems = word_elems(proc_insn.vsew, proc_rem_q);
  assign word_idx   = (proc_insn.vl - proc_rem_q) >> (2'd3 - proc_insn.vsew);
  assign proc_addr  = VAddrWidth'(proc_insn.vd) * VAddrWidth'(WordsPerVReg) +
                      VAddrWidth'(word_idx);
  assign nbytes     = proc_elems[3:0] << proc_insn.vsew;
  assign be_mask    = (16'd1 << nbytes) - 16'd1;

  assign res_ready_o = !rq_full_i;
  assign push_o      = res_valid_i && !rq_full_i;
  assign push_data_o = '{
    id:    proc_insn.id,
    addr:  ResAddrWidth'(proc_addr),
    wdata: res_data_i,
    be:    strb_t'(be_mask)
  };

  always_comb begin
    accept_pnt_d    = accept_pnt_q;
    issue_pnt_d     = issue_pnt_q;
    proc_pnt_d      = proc_pnt_q;
    commit_pnt_d    = commit_pnt_q;
    issue_cnt_d     = issue_cnt_q;
    proc_cnt_d      = proc_cnt_q;
    commit_cnt_d    = commit_cnt_q;
    issue_rem_d     = issue_rem_q;
    proc_rem_d      = proc_rem_q;
    commit_rem_d    = commit_rem_q;
    operand_ready_o = '0;
    done_o          = '0;

    // One word goes to the array, only needed operands are popped
    if (issue.valid && issue.ready) begin
      operand_ready_o = {issue_insn.op != VMUL, 1'b1, !issue_insn.use_scalar};
      issue_rem_d     = issue_rem_q - word_elems(issue_insn.vsew, issue_rem_q);
      if (issue_rem_d == '0) begin
        issue_cnt_d = issue_cnt_q - 1'b1;
        issue_pnt_d = next_pnt(issue_pnt_q);
        if (issue_cnt_d != '0)
          issue_rem_d = insn_q[issue_pnt_d].vl;
      end
    end

    // Result word enters the result queue
    if (push_o) begin
      proc_rem_d = proc_rem_q - proc_elems;
      if (proc_rem_d == '0) begin
        proc_cnt_d = proc_cnt_q - 1'b1;
        proc_pnt_d = next_pnt(proc_pnt_q);
        if (proc_cnt_d != '0)
          proc_rem_d = insn_q[proc_pnt_d].vl;
      end
    end

    // Register file took a word
    if (gnt_i) begin
      commit_rem_d = commit_rem_q - word_elems(commit_insn.vsew, commit_rem_q);
      if (commit_rem_d == '0) begin
        done_o[commit_insn.id] = 1'b1;
        commit_cnt_d           = commit_cnt_q - 1'b1;
        commit_pnt_d           = next_pnt(commit_pnt_q);
        if (commit_cnt_d != '0)
          commit_rem_d = insn_q[commit_pnt_d].vl;
      end
    end

    // First instruction of an empty phase loads its element counter
    if (op_valid_i && op_ready_o) begin
      accept_pnt_d = next_pnt(accept_pnt_q);
      if (issue_cnt_d == '0)
        issue_rem_d = op_i.vl;
      if (proc_cnt_d == '0)
        proc_rem_d = op_i.vl;
      if (commit_cnt_d == '0)
        commit_rem_d = op_i.vl;
      issue_cnt_d  = issue_cnt_d + 1'b1;
      proc_cnt_d   = proc_cnt_d + 1'b1;
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
      issue_rem_q  <= '0;
      proc_rem_q   <= '0;
      commit_rem_q <= '0;
    end else begin
      accept_pnt_q <= accept_pnt_d;
      issue_pnt_q  <= issue_pnt_d;
      proc_pnt_q   <= proc_pnt_d;
      commit_pnt_q <= commit_pnt_d;
      issue_cnt_q  <= issue_cnt_d;
      proc_cnt_q   <= proc_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      issue_rem_q  <= issue_rem_d;
      proc_rem_q   <= proc_rem_d;
      commit_rem_q <= commit_rem_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_valid_i && op_ready_o)
      insn_q[accept_pnt_q] <= op_i;
  end

endmodule

// File: src/vmul_issue_if.sv
// Issue channel from the instruction queue to the multiplier array
// Carries one word of operands plus the operation that applies to it
`timescale 1ns/1ps
interface vmul_issue_if;
  import vmul_pkg::*;

  logic    valid;
  logic    ready;
  mul_op_e op;
  vew_e    vsew;
  logic    use_scalar;
  elen_t   scalar;
  elen_t   operand_a;
  elen_t   operand_b;
  elen_t   operand_c;

  modport issuer (
    output valid, op, vsew, use_scalar, scalar,
    output operand_a, operand_b, operand_c,
    input  ready
  );

  modport executor (
    input  valid, op, vsew, use_scalar, scalar,
    input  operand_a, operand_b, operand_c,
    output ready
  );

endinterface

// File: src/vmul_pkg.sv
// Shared types and constants of the vector integer multiply unit
// Widths, instruction and result formats, and multiplier latencies
package vmul_pkg;

  localparam int unsigned ElenWidth = 64;
  localparam int unsigned NrVInsn   = 8;

  // Each vector register covers this many consecutive words
  localparam int unsigned WordsPerVReg = 32;

  // Address field carried in a result payload
  localparam int unsigned ResAddrWidth = 8;

  typedef logic [ElenWidth-1:0]   elen_t;
  typedef logic [ElenWidth/8-1:0] strb_t;
  typedef logic [2:0]             vid_t;
  typedef logic [9:0]             vlen_t;
  typedef logic [4:0]             vreg_t;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMACC  = 2'd1,
    VNMSAC = 2'd2
  } mul_op_e;

  typedef struct packed {
    vid_t    id;
    mul_op_e op;
    vew_e    vsew;
    vlen_t   vl;
    vreg_t   vd;
    logic    use_scalar;
    elen_t   scalar;
  } vmul_insn_t;

  typedef struct packed {
    vid_t                    id;
    logic [ResAddrWidth-1:0] addr;
    elen_t                   wdata;
    strb_t                   be;
  } vmul_result_t;

  // Pipeline depth of each SIMD multiplier
  localparam int unsigned LatMulEW8  = 1;
  localparam int unsigned LatMulEW16 = 1;
  localparam int unsigned LatMulEW32 = 2;
  localparam int unsigned LatMulEW64 = 2;

endpackage
